//--- include/coherence_defs.svh
// Build-time constants for the two-processor MESI snooping subsystem
// Sizes the processor ports, the line stores and the memory timing
`ifndef COHERENCE_DEFS_SVH
`define COHERENCE_DEFS_SVH

`define N_CPUS      2   // Processor ports
`define ADDR_W      16  // Byte address width
`define LINE_WORDS  2   // 32-bit words per line
`define N_SETS      4   // Sets per line store
`define MEM_LATENCY 3   // Memory strobe to done, in cycles

`endif

//--- source/coherence_pkg.sv
// MESI coherence types
// Line state and coherency unit FSM state shared across the subsystem
package coherence_pkg;

    typedef enum logic [1:0] {
        MODIFIED,
        EXCLUSIVE,
        SHARED,
        INVALID
    } mesi_t;

    typedef enum logic [2:0] {
        IDLE,
        WRITE_REQ,
        READ_REQ,
        RESP_CHKTAG,
        RESP_SEND,
        WRITEBACK
    } cu_state_t;

endpackage

//--- source/line_store.sv
// Direct-mapped line store
// Tag, MESI state and data per set, read combinationally from a processor
// side and a snoop side; fills, word writes and snoop downgrades update it
`timescale 1ns/100ps
`include "coherence_defs.svh"

module line_store
    import coherence_pkg::*;
(
    input  logic                      CLK,
    input  logic                      nRST,
    input  logic [`ADDR_W-1:0]        lookup_addr,
    output logic                      hit,
    output mesi_t                     state,
    output logic [`LINE_WORDS*32-1:0] line,
    output logic [`ADDR_W-1:0]        victim_addr,
    input  logic                      write_word,
    input  logic [31:0]               word_data,
    input  logic                      fill,
    input  logic [`LINE_WORDS*32-1:0] fill_line,
    input  mesi_t                     fill_state,
    input  logic                      snoop_req,
    input  logic [`ADDR_W-1:0]        snoop_addr,
    output logic                      snoop_hit,
    output logic                      snoop_dirty,
    output logic [`LINE_WORDS*32-1:0] snoop_line,
    input  logic                      snoop_set_state,
    input  mesi_t                     snoop_state
);
    localparam WORD_W = $clog2(`LINE_WORDS);
    localparam OFF_W  = 2 + WORD_W;
    localparam IDX_W  = $clog2(`N_SETS);
    localparam TAG_W  = `ADDR_W - OFF_W - IDX_W;

    logic [TAG_W-1:0]          tag_mem   [`N_SETS];
    mesi_t                     state_mem [`N_SETS];
    logic [`LINE_WORDS*32-1:0] data_mem  [`N_SETS];

    logic [IDX_W-1:0]  idx;
    logic [IDX_W-1:0]  sidx;
    logic [TAG_W-1:0]  ltag;
    logic [TAG_W-1:0]  stag;
    logic [WORD_W-1:0] word;

    assign idx  = lookup_addr[OFF_W +: IDX_W];
    assign ltag = lookup_addr[`ADDR_W-1 -: TAG_W];
    assign word = lookup_addr[2 +: WORD_W];
    assign sidx = snoop_addr[OFF_W +: IDX_W];
    assign stag = snoop_addr[`ADDR_W-1 -: TAG_W];

    assign state       = state_mem[idx];  // Raw set state, also the victim state
    assign hit         = (state_mem[idx] != INVALID) && (tag_mem[idx] == ltag);
    assign line        = data_mem[idx];
    assign victim_addr = {tag_mem[idx], idx, {OFF_W{1'b0}}};

    assign snoop_hit   = snoop_req && (state_mem[sidx] != INVALID) && (tag_mem[sidx] == stag);
    assign snoop_dirty = snoop_hit && (state_mem[sidx] == MODIFIED);
    assign snoop_line  = data_mem[sidx];

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            for (int i = 0; i < `N_SETS; i++) begin
                state_mem[i] <= INVALID;
            end
        end else if (fill) begin
            state_mem[idx] <= fill_state;
        end else if (write_word) begin
            state_mem[idx] <= MODIFIED;  // Silent E to M
        end else if (snoop_set_state && snoop_hit) begin
            state_mem[sidx] <= snoop_state;
        end
    end

    always_ff @(posedge CLK) begin
        if (fill) begin
            tag_mem[idx]  <= ltag;
            data_mem[idx] <= fill_line;
        end else if (write_word) begin
            data_mem[idx][word*32 +: 32] <= word_data;
        end
    end

endmodule

//--- source/coherency_unit.sv
// Per-processor MESI coherency unit
// Serves hits from the line store, takes misses, upgrades and victim
// write-backs to the shared bus, and answers snoops from other units
`timescale 1ns/100ps
`include "coherence_defs.svh"

module coherency_unit
    import coherence_pkg::*;
(
    input  logic                      CLK,
    input  logic                      nRST,
    input  logic                      ren,
    input  logic                      wen,
    input  logic [`ADDR_W-1:0]        addr,
    input  logic [31:0]               wdata,
    output logic [31:0]               rdata,
    output logic                      busy,
    output logic [`ADDR_W-1:0]        lookup_addr,
    input  logic                      hit,
    input  mesi_t                     line_state,
    input  logic [`LINE_WORDS*32-1:0] line,
    input  logic [`ADDR_W-1:0]        victim_addr,
    output logic                      write_word,
    output logic [31:0]               word_data,
    output logic                      fill,
    output logic [`LINE_WORDS*32-1:0] fill_line,
    output mesi_t                     fill_state,
    output logic                      ls_snoop_req,
    output logic [`ADDR_W-1:0]        ls_snoop_addr,
    input  logic                      ls_snoop_hit,
    input  logic                      ls_snoop_dirty,
    input  logic [`LINE_WORDS*32-1:0] ls_snoop_line,
    output logic                      snoop_set_state,
    output mesi_t                     snoop_state,
    output logic                      bus_ren,
    output logic                      bus_rdx,
    output logic                      bus_wb,
    output logic [`ADDR_W-1:0]        bus_addr,
    output logic [`LINE_WORDS*32-1:0] bus_store,
    input  logic                      dwait,
    input  logic [`LINE_WORDS*32-1:0] dload,
    input  logic                      exclusive,
    input  logic                      ccwait,
    input  logic [`ADDR_W-1:0]        snoop_addr,
    input  logic                      snoop_inv,
    output logic                      snoop_done,
    output logic                      snoop_hit,
    output logic                      snoop_dirty,
    output logic [`LINE_WORDS*32-1:0] snoop_line
);
    localparam WORD_W = $clog2(`LINE_WORDS);
    localparam OFF_W  = 2 + WORD_W;

    cu_state_t                 state;
    cu_state_t                 next_state;
    logic                      done_q;      // Local hit completes this cycle
    logic                      local_hit;
    logic [WORD_W-1:0]         word_sel;
    logic [`LINE_WORDS*32-1:0] merged;

    assign word_sel      = addr[2 +: WORD_W];
    assign lookup_addr   = addr;
    assign word_data     = wdata;
    assign ls_snoop_addr = snoop_addr;
    assign local_hit     = hit && (ren || line_state != SHARED);  // S needs an upgrade
    assign rdata = (state == READ_REQ) ? dload[word_sel*32 +: 32] : line[word_sel*32 +: 32];

    always_comb begin
        merged = dload;
        merged[word_sel*32 +: 32] = wdata;  // Written word over the fetched line
    end

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            state  <= IDLE;
            done_q <= 1'b0;
        end else begin
            state  <= next_state;
            done_q <= (state == IDLE) && !done_q && !ccwait && (ren || wen) && local_hit;
        end
    end

    always_comb begin
        next_state      = state;
        busy            = 1'b1;
        write_word      = 1'b0;
        fill            = 1'b0;
        fill_line       = dload;
        fill_state      = INVALID;
        ls_snoop_req    = 1'b0;
        snoop_set_state = 1'b0;
        snoop_state     = INVALID;
        bus_ren         = 1'b0;
        bus_rdx         = 1'b0;
        bus_wb          = 1'b0;
        bus_addr        = {addr[`ADDR_W-1:OFF_W], {OFF_W{1'b0}}};
        bus_store       = line;
        snoop_done      = 1'b0;
        snoop_hit       = 1'b0;
        snoop_dirty     = 1'b0;
        snoop_line      = ls_snoop_line;

        case (state)
            IDLE: begin
                busy = !done_q;
                if (!done_q) begin
                    if (ccwait) begin  // Snoops go first
                        next_state = RESP_CHKTAG;
                    end else if (ren || wen) begin
                        if (local_hit) begin
                            write_word = wen;
                        end else if (!hit && line_state == MODIFIED) begin
                            next_state = WRITEBACK;
                        end else begin
                            next_state = wen ? WRITE_REQ : READ_REQ;
                        end
                    end
                end
            end
            READ_REQ: begin
                bus_ren = 1'b1;
                if (ccwait) begin
                    next_state = RESP_CHKTAG;
                end else if (!dwait) begin
                    fill       = 1'b1;
                    fill_state = exclusive ? EXCLUSIVE : SHARED;
                    busy       = 1'b0;
                    next_state = IDLE;
                end
            end
            WRITE_REQ: begin  // I to M and S to M
                bus_rdx = 1'b1;
                if (ccwait) begin
                    next_state = RESP_CHKTAG;
                end else if (!dwait) begin
                    fill       = 1'b1;
                    fill_line  = merged;
                    fill_state = MODIFIED;
                    busy       = 1'b0;
                    next_state = IDLE;
                end
            end
            WRITEBACK: begin
                bus_wb   = 1'b1;
                bus_addr = victim_addr;
                if (ccwait) begin
                    next_state = RESP_CHKTAG;
                end else if (!dwait) begin
                    fill       = 1'b1;  // Drop the victim, request reissues from IDLE
                    fill_line  = line;
                    next_state = IDLE;
                end
            end
            RESP_CHKTAG: begin
                ls_snoop_req = 1'b1;
                if (ls_snoop_hit) begin
                    next_state = RESP_SEND;
                end else begin
                    snoop_done = 1'b1;
                    if (!ccwait) begin
                        next_state = IDLE;
                    end
                end
            end
            RESP_SEND: begin
                ls_snoop_req    = 1'b1;
                snoop_done      = 1'b1;
                snoop_hit       = 1'b1;
                snoop_dirty     = ls_snoop_dirty;
                snoop_set_state = 1'b1;
                snoop_state     = snoop_inv ? INVALID : SHARED;
                if (!ccwait) begin
                    next_state = IDLE;
                end
            end
            default: next_state = IDLE;
        endcase
    end

    a_reply_to_requester: assert property (@(posedge CLK) disable iff (!nRST)
        !dwait |-> (bus_ren || bus_rdx || bus_wb));

    a_no_snoop_in_reply: assert property (@(posedge CLK) disable iff (!nRST)
        !(ccwait && !dwait));  // A snoop here would lose the fill

endmodule

//--- source/bus_controller.sv
// Snooping bus controller
// Grants one coherency unit at a time, broadcasts the snoop to the others,
// collects their replies and moves whole lines to and from main memory
`timescale 1ns/100ps
`include "coherence_defs.svh"

module bus_controller (
    input  logic                                    CLK,
    input  logic                                    nRST,
    input  logic [`N_CPUS-1:0]                      bus_ren,
    input  logic [`N_CPUS-1:0]                      bus_rdx,
    input  logic [`N_CPUS-1:0]                      bus_wb,
    input  logic [`N_CPUS-1:0][`ADDR_W-1:0]         bus_addr,
    input  logic [`N_CPUS-1:0][`LINE_WORDS*32-1:0]  bus_store,
    output logic [`N_CPUS-1:0]                      dwait,
    output logic [`N_CPUS-1:0][`LINE_WORDS*32-1:0]  dload,
    output logic [`N_CPUS-1:0]                      exclusive,
    output logic [`N_CPUS-1:0]                      ccwait,
    output logic [`N_CPUS-1:0][`ADDR_W-1:0]         snoop_addr,
    output logic [`N_CPUS-1:0]                      snoop_inv,
    input  logic [`N_CPUS-1:0]                      snoop_done,
    input  logic [`N_CPUS-1:0]                      snoop_hit,
    input  logic [`N_CPUS-1:0]                      snoop_dirty,
    input  logic [`N_CPUS-1:0][`LINE_WORDS*32-1:0]  snoop_line,
    output logic                                    mem_ren,
    output logic                                    mem_wen,
    output logic [`ADDR_W-1:0]                      mem_addr,
    output logic [`LINE_WORDS*32-1:0]               mem_wdata,
    input  logic [`LINE_WORDS*32-1:0]               mem_rdata,
    input  logic                                    mem_done
);
    localparam CPU_W = (`N_CPUS > 1) ? $clog2(`N_CPUS) : 1;

    typedef enum logic [2:0] {PH_IDLE, PH_SNOOP, PH_FLUSH, PH_MEM, PH_REPLY} phase_t;

    phase_t                    phase;
    logic [CPU_W-1:0]          grant;
    logic [CPU_W-1:0]          pick;
    logic [`N_CPUS-1:0]        req;
    logic [`N_CPUS-1:0]        others;   // Every CPU but the granted one
    logic [`N_CPUS-1:0]        fresh;    // Snoop replies not yet recorded
    logic [`N_CPUS-1:0]        seen_q;
    logic [`N_CPUS-1:0]        hit_q;
    logic [`N_CPUS-1:0]        dirty_q;
    logic                      all_seen;
    logic                      rdx_q;
    logic [`ADDR_W-1:0]        addr_q;
    logic [`LINE_WORDS*32-1:0] data_q;

    always_comb begin
        req  = bus_ren | bus_rdx | bus_wb;
        pick = '0;
        for (int i = `N_CPUS-1; i >= 0; i--) begin  // Lowest number wins
            if (req[i]) begin
                pick = CPU_W'(i);
            end
        end
        for (int i = 0; i < `N_CPUS; i++) begin
            others[i] = (CPU_W'(i) != grant);
        end
    end

    assign fresh    = snoop_done & others & ~seen_q;
    assign all_seen = &(seen_q | fresh | ~others);

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            phase   <= PH_IDLE;
            grant   <= '0;
            rdx_q   <= 1'b0;
            seen_q  <= '0;
            hit_q   <= '0;
            dirty_q <= '0;
        end else begin
            case (phase)
                PH_IDLE: begin
                    if (|req) begin
                        grant   <= pick;
                        rdx_q   <= bus_rdx[pick];
                        seen_q  <= '0;
                        hit_q   <= '0;
                        dirty_q <= '0;
                        phase   <= bus_wb[pick] ? PH_FLUSH : PH_SNOOP;  // Write-back skips snoop
                    end
                end
                PH_SNOOP: begin
                    seen_q  <= seen_q | fresh;
                    hit_q   <= hit_q | (fresh & snoop_hit);
                    dirty_q <= dirty_q | (fresh & snoop_dirty);
                    if (all_seen) begin
                        phase <= (|(dirty_q | (fresh & snoop_dirty))) ? PH_FLUSH : PH_MEM;
                    end
                end
                PH_FLUSH,
                PH_MEM: begin
                    if (mem_done) begin
                        phase <= PH_REPLY;
                    end
                end
                default: phase <= PH_IDLE;  // Reply lasts one cycle
            endcase
        end
    end

    always_ff @(posedge CLK) begin
        if (phase == PH_IDLE && |req) begin
            addr_q <= bus_addr[pick];
            data_q <= bus_store[pick];
        end else if (phase == PH_SNOOP) begin
            for (int i = 0; i < `N_CPUS; i++) begin
                if (fresh[i] && snoop_dirty[i]) begin
                    data_q <= snoop_line[i];  // Dirty supplier's line
                end
            end
        end else if (phase == PH_MEM && mem_done) begin
            data_q <= mem_rdata;
        end
    end

    always_comb begin
        for (int i = 0; i < `N_CPUS; i++) begin
            ccwait[i]     = (phase == PH_SNOOP) && others[i] && !seen_q[i];
            dwait[i]      = !((phase == PH_REPLY) && !others[i]);
            dload[i]      = data_q;
            exclusive[i]  = !(|hit_q);
            snoop_addr[i] = addr_q;
            snoop_inv[i]  = rdx_q;
        end
    end

    assign mem_wen   = (phase == PH_FLUSH);
    assign mem_ren   = (phase == PH_MEM);
    assign mem_addr  = addr_q;
    assign mem_wdata = data_q;

    a_one_dirty_supplier: assert property (@(posedge CLK) disable iff (!nRST)
        $onehot0(snoop_dirty));

    a_grant_held: assert property (@(posedge CLK) disable iff (!nRST)
        phase != PH_IDLE |-> req[grant]);  // A snooped requester would drop it

endmodule

//--- source/main_memory.sv
// Line-wide main memory with a fixed access latency
// Cleared at reset; done pulses `MEM_LATENCY cycles after a strobe
`timescale 1ns/100ps
`include "coherence_defs.svh"

module main_memory #(
    parameter int DEPTH = 256  // Lines
) (
    input  logic                      CLK,
    input  logic                      nRST,
    input  logic                      mem_ren,
    input  logic                      mem_wen,
    input  logic [`ADDR_W-1:0]        mem_addr,
    input  logic [`LINE_WORDS*32-1:0] mem_wdata,
    output logic [`LINE_WORDS*32-1:0] mem_rdata,
    output logic                      mem_done
);
    localparam OFF_W = 2 + $clog2(`LINE_WORDS);

    logic [`LINE_WORDS*32-1:0]        mem [DEPTH];
    logic [$clog2(`MEM_LATENCY+1)-1:0] cnt;
    logic [$clog2(DEPTH)-1:0]          idx;
    logic                              fire;  // Last cycle of an access

    assign idx  = mem_addr[OFF_W +: $clog2(DEPTH)];
    assign fire = (mem_ren || mem_wen) && !mem_done && (cnt == `MEM_LATENCY - 1);

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            cnt      <= '0;
            mem_done <= 1'b0;
            for (int i = 0; i < DEPTH; i++) begin
                mem[i] <= '0;
            end
        end else begin
            mem_done <= fire;
            if (fire) begin
                cnt <= '0;
                if (mem_wen) begin
                    mem[idx] <= mem_wdata;
                end
            end else if ((mem_ren || mem_wen) && !mem_done) begin
                cnt <= cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge CLK) begin
        if (fire && mem_ren) begin
            mem_rdata <= mem[idx];
        end
    end

endmodule

//--- source/coherence_top.sv
// Two-processor MESI snooping subsystem
// One line store and coherency unit per CPU on a shared bus controller
// in front of main memory
`timescale 1ns/100ps
`include "coherence_defs.svh"

module coherence_top
    import coherence_pkg::*;
(
    input  logic                            CLK,
    input  logic                            nRST,
    input  logic [`N_CPUS-1:0]              ren,
    input  logic [`N_CPUS-1:0]              wen,
    input  logic [`N_CPUS-1:0][`ADDR_W-1:0] addr,
    input  logic [`N_CPUS-1:0][31:0]        wdata,
    output logic [`N_CPUS-1:0][31:0]        rdata,
    output logic [`N_CPUS-1:0]              busy
);
    localparam LW = `LINE_WORDS * 32;

    logic [`N_CPUS-1:0]              bus_ren;
    logic [`N_CPUS-1:0]              bus_rdx;
    logic [`N_CPUS-1:0]              bus_wb;
    logic [`N_CPUS-1:0][`ADDR_W-1:0] bus_addr;
    logic [`N_CPUS-1:0][LW-1:0]      bus_store;
    logic [`N_CPUS-1:0]              dwait;
    logic [`N_CPUS-1:0][LW-1:0]      dload;
    logic [`N_CPUS-1:0]              exclusive;
    logic [`N_CPUS-1:0]              ccwait;
    logic [`N_CPUS-1:0][`ADDR_W-1:0] snoop_addr;
    logic [`N_CPUS-1:0]              snoop_inv;
    logic [`N_CPUS-1:0]              snoop_done;
    logic [`N_CPUS-1:0]              snoop_hit;
    logic [`N_CPUS-1:0]              snoop_dirty;
    logic [`N_CPUS-1:0][LW-1:0]      snoop_line;
    logic                            mem_ren;
    logic                            mem_wen;
    logic [`ADDR_W-1:0]              mem_addr;
    logic [LW-1:0]                   mem_wdata;
    logic [LW-1:0]                   mem_rdata;
    logic                            mem_done;

    main_memory i_mem (.*);

    bus_controller i_bus (.*);

    for (genvar i = 0; i < `N_CPUS; i++) begin : g_cpu
        logic [`ADDR_W-1:0] lookup_addr;
        logic [`ADDR_W-1:0] victim_addr;
        logic [`ADDR_W-1:0] ls_snoop_addr;
        logic               hit;
        logic               write_word;
        logic               fill;
        logic               ls_snoop_req;
        logic               ls_snoop_hit;
        logic               ls_snoop_dirty;
        logic               snoop_set_state;
        mesi_t              line_state;
        mesi_t              fill_state;
        mesi_t              snoop_state;
        logic [LW-1:0]      line;
        logic [LW-1:0]      fill_line;
        logic [LW-1:0]      ls_snoop_line;
        logic [31:0]        word_data;

        line_store i_store (
            .CLK, .nRST, .lookup_addr, .hit, .state(line_state), .line, .victim_addr,
            .write_word, .word_data, .fill, .fill_line, .fill_state,
            .snoop_req(ls_snoop_req), .snoop_addr(ls_snoop_addr), .snoop_hit(ls_snoop_hit),
            .snoop_dirty(ls_snoop_dirty), .snoop_line(ls_snoop_line),
            .snoop_set_state, .snoop_state
        );

        coherency_unit i_cu (
            .CLK, .nRST, .ren(ren[i]), .wen(wen[i]), .addr(addr[i]), .wdata(wdata[i]),
            .rdata(rdata[i]), .busy(busy[i]),
            .lookup_addr, .hit, .line_state, .line, .victim_addr, .write_word, .word_data,
            .fill, .fill_line, .fill_state, .ls_snoop_req, .ls_snoop_addr, .ls_snoop_hit,
            .ls_snoop_dirty, .ls_snoop_line, .snoop_set_state, .snoop_state,
            .bus_ren(bus_ren[i]), .bus_rdx(bus_rdx[i]), .bus_wb(bus_wb[i]),
            .bus_addr(bus_addr[i]), .bus_store(bus_store[i]), .dwait(dwait[i]),
            .dload(dload[i]), .exclusive(exclusive[i]), .ccwait(ccwait[i]),
            .snoop_addr(snoop_addr[i]), .snoop_inv(snoop_inv[i]),
            .snoop_done(snoop_done[i]), .snoop_hit(snoop_hit[i]),
            .snoop_dirty(snoop_dirty[i]), .snoop_line(snoop_line[i])
        );
    end

endmodule

//--- dv/coherence_tb.sv
// Testbench for the two-processor MESI snooping subsystem
// Drives both processor ports with directed and LFSR-random reads and
// writes and checks every read against a flat word model
`timescale 1ns/100ps
`include "coherence_defs.svh"

module coherence_tb;

    localparam int      POOL    = 16;       // Word addresses in use
    localparam int      TIMEOUT = 200;      // Cycles per wait for busy low
    localparam [31:0]   TAPS    = 32'h80200003;

    logic                            CLK;
    logic                            nRST;
    logic [`N_CPUS-1:0]              ren;
    logic [`N_CPUS-1:0]              wen;
    logic [`N_CPUS-1:0][`ADDR_W-1:0] addr;
    logic [`N_CPUS-1:0][31:0]        wdata;
    logic [`N_CPUS-1:0][31:0]        rdata;
    logic [`N_CPUS-1:0]              busy;

    logic [31:0] lfsr;
    logic [31:0] model [POOL];  // Expected value of each pool word
    int          errors;
    int          n_pass;
    int          n_fail;
    bit          hung;

    coherence_top i_dut (.*);

    always #20 CLK = ~CLK;

    // Galois LFSR, one step per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        logic        b;
        r = '0;
        for (int i = 0; i < n; i++) begin
            b    = lfsr[0];
            lfsr = lfsr >> 1;
            if (b) begin
                lfsr = lfsr ^ TAPS;
            end
            r = {r[30:0], b};
        end
        return r;
    endfunction

    function automatic logic [`ADDR_W-1:0] pool_addr(input int k);
        logic [`ADDR_W-1:0] a;
        a    = '0;
        a[2] = k[0];  // Word in line
        a[3] = k[1];  // Set bit 0
        a[4] = k[3];  // Set bit 1, splits the pool in halves
        a[9] = k[2];  // Tag bit, two lines per set
        return a;
    endfunction

    // One processor request, held until busy goes low
    task automatic access(input int c, input bit write, input int k, input logic [31:0] d);
        logic [31:0] got;
        bit          ok;
        int          n;
        if (hung) begin
            return;
        end
        @(posedge CLK);
        #2;
        addr[c]  = pool_addr(k);
        wdata[c] = d;
        ren[c]   = !write;
        wen[c]   = write;
        ok       = 1'b0;
        for (n = 0; n < TIMEOUT && !ok; n++) begin
            @(negedge CLK);
            ok = !busy[c];
        end
        got = rdata[c];
        @(posedge CLK);
        #2;
        ren[c] = 1'b0;
        wen[c] = 1'b0;
        assert (ok) else begin
            $display("CPU %0d hung: busy stayed high for %0d cycles on address %h",
                     c, TIMEOUT, pool_addr(k));
            hung = 1'b1;
            errors++;
        end
        if (ok && write) begin
            model[k] = d;
        end else if (ok) begin
            assert (got == model[k]) else begin
                $display("MISMATCH rdata[%0d] at address %h: expected %h, got %h",
                         c, pool_addr(k), model[k], got);
                errors++;
            end
        end
    endtask

    task automatic random_stream(input int c, input int count);
        bit          w;
        int          k;
        logic [31:0] d;
        for (int i = 0; i < count; i++) begin
            w = rand_bits(1);
            k = c * (POOL / 2) + rand_bits(3);  // Own half of the pool
            d = rand_bits(32);
            access(c, w, k, d);
        end
    endtask

    task automatic report_test(input string name, input int errs_before);
        if (errors == errs_before) begin
            $display("test %s: ok", name);
            n_pass++;
        end else begin
            $display("test %s: %0d errors", name, errors - errs_before);
            n_fail++;
        end
    endtask

    initial begin
        int mark;
        int c;
        CLK    = 1'b0;
        nRST   = 1'b0;
        ren    = '0;
        wen    = '0;
        addr   = '0;
        wdata  = '0;
        lfsr   = 32'h3ec4;
        errors = 0;
        n_pass = 0;
        n_fail = 0;
        hung   = 1'b0;
        for (int k = 0; k < POOL; k++) begin
            model[k] = '0;
        end
        repeat (4) @(posedge CLK);
        #2;
        nRST = 1'b1;

        mark = errors;
        repeat (3) begin
            @(negedge CLK);
            assert (busy == '1) else begin
                $display("MISMATCH busy: expected %h, got %h", {`N_CPUS{1'b1}}, busy);
                errors++;
            end
        end
        for (int k = 0; k < POOL; k++) begin
            access(k % `N_CPUS, 1'b0, k, '0);  // Memory starts as zeros
        end
        report_test("1 reset and first reads", mark);

        mark = errors;
        access(0, 1'b1, 0, rand_bits(32));
        access(1, 1'b0, 0, '0);  // Dirty line supplied by CPU 0
        access(0, 1'b0, 0, '0);
        report_test("2 write then remote read", mark);

        mark = errors;
        for (int r = 0; r < 6; r++) begin
            access(r % 2, 1'b1, 2, rand_bits(32));
            access(0, 1'b0, 2, '0);
            access(1, 1'b0, 2, '0);
        end
        report_test("3 alternating writers", mark);

        mark = errors;
        access(0, 1'b1, 0, rand_bits(32));
        access(0, 1'b1, 4, rand_bits(32));  // Same set, evicts a MODIFIED line
        access(0, 1'b1, 5, rand_bits(32));
        access(0, 1'b0, 0, '0);
        access(0, 1'b0, 4, '0);
        access(0, 1'b0, 5, '0);
        access(1, 1'b0, 1, '0);
        access(1, 1'b0, 4, '0);
        report_test("4 same-set evictions", mark);

        mark = errors;
        for (int i = 0; i < 300; i++) begin
            c = rand_bits(1);
            if (rand_bits(1)) begin
                access(c, 1'b1, rand_bits(4), rand_bits(32));
            end else begin
                access(c, 1'b0, rand_bits(4), '0);
            end
        end
        report_test("5 random single CPU", mark);

        mark = errors;
        fork
            random_stream(0, 80);
            random_stream(1, 80);
        join
        report_test("6 random concurrent CPUs", mark);

        $display("tests passed: %0d, failed: %0d", n_pass, n_fail);
        if (errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

//--- sim.f
+incdir+include
source/coherence_pkg.sv
source/line_store.sv
source/coherency_unit.sv
source/bus_controller.sv
source/main_memory.sv
source/coherence_top.sv
dv/coherence_tb.sv
